/* common/axi_lite_if.sv */
`default_nettype none

interface axi_lite_if;
	import rv_pkg::*;

	logic [xlen-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [xlen-1:0] rdata;
	logic rvalid;
	logic rready;
	logic [xlen-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [xlen-1:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;

	modport master (
		output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		input arready, rdata, rvalid, awready, wready, bvalid
	);

	modport slave (
		input araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		output arready, rdata, rvalid, awready, wready, bvalid
	);

endinterface

`default_nettype wire

/* common/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	////////////////////////////////////////
	// sizes and addresses
	////////////////////////////////////////

	localparam int xlen = 32;
	localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;
	localparam int mem_words = 1024;
	localparam int mem_aw = 10; // word index, byte address bits 11:2
	localparam int max_delay_bits = 2; // up to 3 extra response cycles
	localparam logic [15:0] lfsr_seed = 16'hace1;
	localparam logic [15:0] lfsr_taps = 16'hb400; // x^16 + x^14 + x^13 + x^11 + 1
	localparam logic [xlen-1:0] ebreak_inst = 32'h0010_0073;

	////////////////////////////////////////
	// encodings
	////////////////////////////////////////

	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111,
		opc_system = 7'b1110011
	} opcode_e;

	typedef enum logic [4:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_slt,
		op_addi,
		op_lui,
		op_lw,
		op_lb,
		op_lbu,
		op_sw,
		op_sb,
		op_beq,
		op_bne,
		op_jal,
		op_ebreak,
		op_illegal
	} op_e;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_mem_rd,
		st_mem_wr,
		st_writeback,
		st_halt
	} core_state_e;

endpackage

`default_nettype wire

/* core/rv_core.sv */
`default_nettype none

module rv_core (
	input wire clk,
	input wire rst_n,
	axi_lite_if.master ifu_bus,
	axi_lite_if.master lsu_bus,
	output logic [rv_pkg::xlen-1:0] pc,
	output logic wb_valid,
	output logic [4:0] wb_rd,
	output logic [rv_pkg::xlen-1:0] wb_data,
	output logic finished,
	output logic [rv_pkg::xlen-1:0] halt_ret
);
	import rv_pkg::*;

	core_state_e state;
	logic [xlen-1:0] inst_q;
	logic [xlen-1:0] load_q;
	logic ifu_arvalid_q;
	logic lsu_arvalid_q;
	logic lsu_awvalid_q;
	logic lsu_wvalid_q;
	op_e op;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] src1;
	logic [xlen-1:0] src2;
	logic [xlen-1:0] a10;
	logic [xlen-1:0] result;
	logic [xlen-1:0] target;
	logic [xlen-1:0] mem_addr;
	logic [xlen-1:0] store_data;
	logic [xlen-1:0] load_ext;
	logic [7:0] load_byte;
	logic [3:0] store_strb;
	logic taken;
	logic is_load;
	logic is_store;
	logic writes_rd;
	logic stop;

	rv_idu rv_idu_inst (
		.inst(inst_q),
		.op(op),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.imm(imm)
	);

	rv_exu rv_exu_inst (
		.op(op),
		.src1(src1),
		.src2(src2),
		.imm(imm),
		.pc(pc),
		.result(result),
		.taken(taken),
		.target(target),
		.mem_addr(mem_addr),
		.store_data(store_data),
		.store_strb(store_strb)
	);

	rv_regfile rv_regfile_inst (
		.clk(clk),
		.we(wb_valid && writes_rd),
		.waddr(rd),
		.wdata(wb_data),
		.raddr1(rs1),
		.raddr2(rs2),
		.rdata1(src1),
		.rdata2(src2),
		.a10(a10)
	);

	assign is_load = (op == op_lw) || (op == op_lb) || (op == op_lbu);
	assign is_store = (op == op_sw) || (op == op_sb);
	assign stop = (op == op_ebreak) || (op == op_illegal);
	assign writes_rd = (op inside {op_add, op_sub, op_and, op_or, op_xor, op_slt, op_addi,
		op_lui, op_lw, op_lb, op_lbu, op_jal});

	////////////////////////////////////////
	// bus channels
	////////////////////////////////////////

	assign ifu_bus.araddr = pc;
	assign ifu_bus.arvalid = ifu_arvalid_q;
	assign ifu_bus.rready = 1'b1;
	assign ifu_bus.awaddr = '0; // fetch side never writes
	assign ifu_bus.awvalid = 1'b0;
	assign ifu_bus.wdata = '0;
	assign ifu_bus.wstrb = '0;
	assign ifu_bus.wvalid = 1'b0;
	assign ifu_bus.bready = 1'b1;

	assign lsu_bus.araddr = mem_addr; // stable, regs only change at writeback
	assign lsu_bus.arvalid = lsu_arvalid_q;
	assign lsu_bus.rready = 1'b1;
	assign lsu_bus.awaddr = mem_addr;
	assign lsu_bus.awvalid = lsu_awvalid_q;
	assign lsu_bus.wdata = store_data;
	assign lsu_bus.wstrb = store_strb;
	assign lsu_bus.wvalid = lsu_wvalid_q;
	assign lsu_bus.bready = 1'b1;

	assign load_byte = lsu_bus.rdata[8*mem_addr[1:0] +: 8];

	always_comb begin
		case (op)
			op_lb: load_ext = {{24{load_byte[7]}}, load_byte};
			op_lbu: load_ext = {24'b0, load_byte};
			default: load_ext = lsu_bus.rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == st_fetch && ifu_bus.rvalid)
			inst_q <= ifu_bus.rdata;
		if (state == st_mem_rd && lsu_bus.rvalid)
			load_q <= load_ext;
	end

	////////////////////////////////////////
	// control
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_fetch;
			pc <= reset_pc;
			ifu_arvalid_q <= 1'b1; // first fetch goes out right after reset
			lsu_arvalid_q <= 1'b0;
			lsu_awvalid_q <= 1'b0;
			lsu_wvalid_q <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					if (ifu_bus.arvalid && ifu_bus.arready)
						ifu_arvalid_q <= 1'b0;
					if (ifu_bus.rvalid)
						state <= st_decode;
				end
				st_decode: begin
					if (is_load) begin
						lsu_arvalid_q <= 1'b1;
						state <= st_mem_rd;
					end else if (is_store) begin
						lsu_awvalid_q <= 1'b1; // aw and w go out together
						lsu_wvalid_q <= 1'b1;
						state <= st_mem_wr;
					end else begin
						state <= st_writeback;
					end
				end
				st_mem_rd: begin
					if (lsu_bus.arvalid && lsu_bus.arready)
						lsu_arvalid_q <= 1'b0;
					if (lsu_bus.rvalid)
						state <= st_writeback;
				end
				st_mem_wr: begin
					if (lsu_bus.awvalid && lsu_bus.awready)
						lsu_awvalid_q <= 1'b0;
					if (lsu_bus.wvalid && lsu_bus.wready)
						lsu_wvalid_q <= 1'b0;
					if (lsu_bus.bvalid)
						state <= st_writeback;
				end
				st_writeback: begin
					if (stop) begin
						state <= st_halt; // pc keeps the halting address
					end else begin
						pc <= taken ? target : pc + 32'd4;
						ifu_arvalid_q <= 1'b1;
						state <= st_fetch;
					end
				end
				st_halt: state <= st_halt;
				default: state <= st_halt;
			endcase
		end
	end

	assign wb_valid = (state == st_writeback);
	assign finished = (state == st_halt);
	assign wb_rd = writes_rd ? rd : 5'd0;
	assign wb_data = (wb_rd == 5'd0) ? '0 : (is_load ? load_q : result);
	assign halt_ret = !finished ? '0 : ((op == op_illegal) ? '1 : a10);

	// each retirement is followed by at least a fetch and a decode
	assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> !$past(wb_valid) && !$past(wb_valid, 2) && !$past(wb_valid, 3));

	assert property (@(posedge clk) disable iff (!rst_n)
		ifu_bus.arvalid && !ifu_bus.arready |=> ifu_bus.arvalid && $stable(ifu_bus.araddr));

endmodule

`default_nettype wire

/* core/rv_exu.sv */
`default_nettype none

module rv_exu (
	input var rv_pkg::op_e op,
	input wire [rv_pkg::xlen-1:0] src1,
	input wire [rv_pkg::xlen-1:0] src2,
	input wire [rv_pkg::xlen-1:0] imm,
	input wire [rv_pkg::xlen-1:0] pc,
	output logic [rv_pkg::xlen-1:0] result,
	output logic taken,
	output logic [rv_pkg::xlen-1:0] target,
	output logic [rv_pkg::xlen-1:0] mem_addr,
	output logic [rv_pkg::xlen-1:0] store_data,
	output logic [3:0] store_strb
);
	import rv_pkg::*;

	assign mem_addr = src1 + imm;
	assign target = pc + imm; // branch and jal share the pc relative form

	always_comb begin
		result = '0;
		taken = 1'b0;
		case (op)
			op_add: result = src1 + src2;
			op_sub: result = src1 - src2;
			op_and: result = src1 & src2;
			op_or: result = src1 | src2;
			op_xor: result = src1 ^ src2;
			op_slt: result = {31'b0, $signed(src1) < $signed(src2)};
			op_addi: result = src1 + imm;
			op_lui: result = imm;
			op_jal: begin
				result = pc + 32'd4; // link value
				taken = 1'b1;
			end
			op_beq: taken = (src1 == src2);
			op_bne: taken = (src1 != src2);
			default: result = '0;
		endcase
	end

	always_comb begin
		store_data = src2;
		store_strb = 4'b0000;
		if (op == op_sb) begin
			store_data = {4{src2[7:0]}}; // memory picks the lane by strobe
			store_strb = 4'b0001 << mem_addr[1:0];
		end else if (op == op_sw) begin
			store_strb = 4'b1111;
		end
	end

endmodule

`default_nettype wire

/* core/rv_idu.sv */
`default_nettype none

module rv_idu (
	input wire [rv_pkg::xlen-1:0] inst,
	output rv_pkg::op_e op,
	output logic [4:0] rd,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [rv_pkg::xlen-1:0] imm
);
	import rv_pkg::*;

	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd = inst[11:7];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];

	always_comb begin
		op = op_illegal;
		imm = '0;
		case (opcode)
			opc_op: begin
				case ({funct7, funct3})
					10'b0000000_000: op = op_add;
					10'b0100000_000: op = op_sub;
					10'b0000000_111: op = op_and;
					10'b0000000_110: op = op_or;
					10'b0000000_100: op = op_xor;
					10'b0000000_010: op = op_slt;
					default: op = op_illegal;
				endcase
			end
			opc_op_imm: begin
				imm = {{20{inst[31]}}, inst[31:20]};
				if (funct3 == 3'b000)
					op = op_addi;
			end
			opc_lui: begin
				imm = {inst[31:12], 12'b0};
				op = op_lui;
			end
			opc_load: begin
				imm = {{20{inst[31]}}, inst[31:20]};
				case (funct3)
					3'b010: op = op_lw;
					3'b000: op = op_lb;
					3'b100: op = op_lbu;
					default: op = op_illegal;
				endcase
			end
			opc_store: begin
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
				case (funct3)
					3'b010: op = op_sw;
					3'b000: op = op_sb;
					default: op = op_illegal;
				endcase
			end
			opc_branch: begin
				imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
				case (funct3)
					3'b000: op = op_beq;
					3'b001: op = op_bne;
					default: op = op_illegal;
				endcase
			end
			opc_jal: begin
				imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
				op = op_jal;
			end
			opc_system: begin
				if (inst == ebreak_inst)
					op = op_ebreak; // ecall and csr forms stay illegal
			end
			default: op = op_illegal;
		endcase
	end

endmodule

`default_nettype wire

/* core/rv_regfile.sv */
`default_nettype none

module rv_regfile (
	input wire clk,
	input wire we,
	input wire [4:0] waddr,
	input wire [rv_pkg::xlen-1:0] wdata,
	input wire [4:0] raddr1,
	input wire [4:0] raddr2,
	output logic [rv_pkg::xlen-1:0] rdata1,
	output logic [rv_pkg::xlen-1:0] rdata2,
	output logic [rv_pkg::xlen-1:0] a10
);
	import rv_pkg::*;

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (we && waddr != 5'd0)
			regs[waddr] <= wdata;
	end

	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];
	assign a10 = regs[10];

endmodule

`default_nettype wire

/* hw/axi_sram.sv */
`default_nettype none

module axi_sram (
	input wire clk,
	input wire rst_n,
	axi_lite_if.slave bus,
	input wire prog_we,
	input wire [rv_pkg::mem_aw-1:0] prog_addr,
	input wire [rv_pkg::xlen-1:0] prog_wdata
);
	import rv_pkg::*;

	typedef enum logic [1:0] {
		sr_idle,
		sr_read,
		sr_write
	} sram_state_e;

	logic [xlen-1:0] mem [mem_words];
	logic [xlen-1:0] rdata_q;
	sram_state_e state;
	logic [max_delay_bits-1:0] delay_cnt;
	logic [15:0] lfsr;
	logic rd_accept;
	logic wr_accept;
	logic [mem_aw-1:0] ar_idx;
	logic [mem_aw-1:0] aw_idx;

	assign ar_idx = bus.araddr[mem_aw+1:2]; // upper address bits are ignored
	assign aw_idx = bus.awaddr[mem_aw+1:2];

	assign bus.arready = (state == sr_idle);
	assign bus.awready = (state == sr_idle);
	assign bus.wready = (state == sr_idle);
	assign rd_accept = bus.arvalid && bus.arready;
	assign wr_accept = bus.awvalid && bus.awready && bus.wvalid && bus.wready;

	assign bus.rdata = rdata_q;
	assign bus.rvalid = (state == sr_read) && (delay_cnt == '0);
	assign bus.bvalid = (state == sr_write) && (delay_cnt == '0);

	////////////////////////////////////////
	// storage
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			if (prog_we)
				mem[prog_addr] <= prog_wdata; // program image goes in under reset
		end else if (wr_accept) begin
			for (int i = 0; i < 4; i++) begin
				if (bus.wstrb[i])
					mem[aw_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
			end
		end
		if (rd_accept)
			rdata_q <= mem[ar_idx];
	end

	////////////////////////////////////////
	// response timing
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= sr_idle;
			delay_cnt <= '0;
			lfsr <= lfsr_seed;
		end else begin
			if (rd_accept || wr_accept) begin
				delay_cnt <= lfsr[max_delay_bits-1:0];
				lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? lfsr_taps : 16'h0000);
				state <= rd_accept ? sr_read : sr_write;
			end else if (state != sr_idle) begin
				if (delay_cnt != '0)
					delay_cnt <= delay_cnt - 1'b1;
				else if ((bus.rvalid && bus.rready) || (bus.bvalid && bus.bready))
					state <= sr_idle;
			end
		end
	end

	// a write is only taken with address and data side by side
	assert property (@(posedge clk) disable iff (!rst_n) bus.awvalid == bus.wvalid);

endmodule

`default_nettype wire

/* hw/axi_xbar.sv */
`default_nettype none

module axi_xbar (
	input wire clk,
	input wire rst_n,
	axi_lite_if.slave ifu,
	axi_lite_if.slave lsu,
	axi_lite_if.master mem
);

	typedef enum logic [1:0] {
		gnt_idle,
		gnt_ifu,
		gnt_lsu
	} grant_e;

	grant_e grant;
	grant_e sel;
	logic addr_done;
	logic resp_done;

	// lsu wins when both ask in the same idle cycle
	always_comb begin
		sel = grant;
		if (grant == gnt_idle) begin
			if (lsu.arvalid || lsu.awvalid)
				sel = gnt_lsu;
			else if (ifu.arvalid)
				sel = gnt_ifu;
		end
	end

	assign addr_done = (mem.arvalid && mem.arready) || (mem.awvalid && mem.awready);
	assign resp_done = (mem.rvalid && mem.rready) || (mem.bvalid && mem.bready);

	always_ff @(posedge clk) begin
		if (!rst_n)
			grant <= gnt_idle;
		else if (grant == gnt_idle && addr_done)
			grant <= sel;
		else if (grant != gnt_idle && resp_done)
			grant <= gnt_idle;
	end

	////////////////////////////////////////
	// routing
	////////////////////////////////////////

	assign mem.araddr = (sel == gnt_lsu) ? lsu.araddr : ifu.araddr;
	assign mem.arvalid = (sel == gnt_lsu) ? lsu.arvalid : ((sel == gnt_ifu) && ifu.arvalid);
	assign mem.rready = (sel == gnt_lsu) ? lsu.rready : ((sel == gnt_ifu) && ifu.rready);
	assign mem.awaddr = lsu.awaddr; // only the lsu writes
	assign mem.awvalid = (sel == gnt_lsu) && lsu.awvalid;
	assign mem.wdata = lsu.wdata;
	assign mem.wstrb = lsu.wstrb;
	assign mem.wvalid = (sel == gnt_lsu) && lsu.wvalid;
	assign mem.bready = (sel == gnt_lsu) && lsu.bready;

	assign ifu.arready = (sel == gnt_ifu) && mem.arready;
	assign ifu.rdata = mem.rdata;
	assign ifu.rvalid = (sel == gnt_ifu) && mem.rvalid;
	assign ifu.awready = 1'b0;
	assign ifu.wready = 1'b0;
	assign ifu.bvalid = 1'b0;

	assign lsu.arready = (sel == gnt_lsu) && mem.arready;
	assign lsu.rdata = mem.rdata;
	assign lsu.rvalid = (sel == gnt_lsu) && mem.rvalid;
	assign lsu.awready = (sel == gnt_lsu) && mem.awready;
	assign lsu.wready = (sel == gnt_lsu) && mem.wready;
	assign lsu.bvalid = (sel == gnt_lsu) && mem.bvalid;

	// a response only comes back while its grant is still held
	assert property (@(posedge clk) disable iff (!rst_n)
		(mem.rvalid || mem.bvalid) |-> (grant != gnt_idle));

endmodule

`default_nettype wire

/* hw/rv_soc_top.sv */
`default_nettype none

module rv_soc_top (
	input wire clk,
	input wire rst_n,
	input wire prog_we,
	input wire [rv_pkg::mem_aw-1:0] prog_addr,
	input wire [31:0] prog_wdata,
	output logic [31:0] pc,
	output logic wb_valid,
	output logic [4:0] wb_rd,
	output logic [31:0] wb_data,
	output logic finished,
	output logic [31:0] halt_ret
);

	axi_lite_if ifu_bus ();
	axi_lite_if lsu_bus ();
	axi_lite_if mem_bus ();

	rv_core rv_core_inst (
		.clk(clk),
		.rst_n(rst_n),
		.ifu_bus(ifu_bus.master),
		.lsu_bus(lsu_bus.master),
		.pc(pc),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.finished(finished),
		.halt_ret(halt_ret)
	);

	axi_xbar axi_xbar_inst (
		.clk(clk),
		.rst_n(rst_n),
		.ifu(ifu_bus.slave),
		.lsu(lsu_bus.slave),
		.mem(mem_bus.master)
	);

	axi_sram axi_sram_inst (
		.clk(clk),
		.rst_n(rst_n),
		.bus(mem_bus.slave),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_wdata(prog_wdata)
	);

endmodule

`default_nettype wire

/* list.f */
common/rv_pkg.sv
common/axi_lite_if.sv
core/rv_regfile.sv
core/rv_idu.sv
core/rv_exu.sv
core/rv_core.sv
hw/axi_xbar.sv
hw/axi_sram.sv
hw/rv_soc_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module tb_top \
	-f list.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
exit 1

/* testbench/tb_checker.sv */
`default_nettype none

module tb_checker (
	input wire clk,
	input wire rst_n,
	input wire [31:0] pc,
	input wire wb_valid,
	input wire [4:0] wb_rd,
	input wire [31:0] wb_data,
	input wire finished,
	input wire [31:0] halt_ret,
	output int error_count,
	output int retire_count
);
	timeunit 1ns;
	timeprecision 100ps;
	import rv_pkg::*;

	logic [31:0] prog_image [mem_words]; // filled from tb_top before reset is released
	logic [31:0] poison_pc;

	logic [31:0] shadow_mem [mem_words];
	logic [31:0] shadow_regs [32];
	logic [31:0] model_pc;
	logic model_halted;
	logic model_illegal;
	logic release_seen;
	logic finished_seen;
	logic prev_wb;
	logic [31:0] want_pc;
	logic [4:0] want_rd;
	logic [31:0] want_data;
	logic [31:0] want_next;

	task automatic value_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Fail at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
		error_count++;
	endtask

	task automatic protocol_error(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	////////////////////////////////////////
	// ISA reference model
	////////////////////////////////////////

	// executes the instruction at model_pc on the shadow state
	function automatic void exec_model(
		output logic [31:0] exp_pc,
		output logic [4:0] exp_rd,
		output logic [31:0] exp_data,
		output logic [31:0] next_pc
	);
		logic [31:0] inst;
		logic [6:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [4:0] rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [31:0] addr;
		logic [31:0] word;
		logic [4:0] sh;
		logic [7:0] lane;
		logic [31:0] val;
		logic wr;

		inst = shadow_mem[model_pc[11:2]];
		opc = inst[6:0];
		f3 = inst[14:12];
		f7 = inst[31:25];
		rd = inst[11:7];
		a = shadow_regs[inst[19:15]];
		b = shadow_regs[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		exp_pc = model_pc;
		next_pc = model_pc + 32'd4;
		val = '0;
		wr = 1'b0;
		case (opc)
			7'h33: begin
				wr = 1'b1;
				case ({f7, f3})
					10'h000: val = a + b;
					10'h100: val = a - b;
					10'h007: val = a & b;
					10'h006: val = a | b;
					10'h004: val = a ^ b;
					10'h002: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: model_illegal = 1'b1;
				endcase
			end
			7'h13: begin
				wr = 1'b1;
				val = a + imm_i;
				if (f3 != 3'b000)
					model_illegal = 1'b1;
			end
			7'h37: begin
				wr = 1'b1;
				val = {inst[31:12], 12'b0};
			end
			7'h03: begin
				wr = 1'b1;
				addr = a + imm_i;
				word = shadow_mem[addr[11:2]]; // memory wraps on bits 11:2
				sh = {addr[1:0], 3'b000};
				lane = 8'(word >> sh);
				case (f3)
					3'b010: val = word;
					3'b000: val = {{24{lane[7]}}, lane};
					3'b100: val = {24'b0, lane};
					default: model_illegal = 1'b1;
				endcase
			end
			7'h23: begin
				addr = a + imm_s;
				word = shadow_mem[addr[11:2]];
				sh = {addr[1:0], 3'b000};
				if (f3 == 3'b010)
					word = b;
				else if (f3 == 3'b000)
					word = (word & ~(32'hff << sh)) | ({24'b0, b[7:0]} << sh);
				else
					model_illegal = 1'b1;
				shadow_mem[addr[11:2]] = word;
			end
			7'h63: begin
				if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b))
					next_pc = model_pc + imm_b;
				if (f3 != 3'b000 && f3 != 3'b001)
					model_illegal = 1'b1;
			end
			7'h6f: begin
				wr = 1'b1;
				val = model_pc + 32'd4;
				next_pc = model_pc + imm_j;
			end
			default: begin
				if (inst != 32'h0010_0073)
					model_illegal = 1'b1;
				model_halted = 1'b1; // ebreak keeps the pc
				next_pc = model_pc;
			end
		endcase
		exp_rd = (wr && rd != 5'd0) ? rd : 5'd0;
		exp_data = (exp_rd != 5'd0) ? val : 32'd0;
		if (exp_rd != 5'd0)
			shadow_regs[rd] = val;
	endfunction

	////////////////////////////////////////
	// compare on the retirement port
	////////////////////////////////////////

	always @(negedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < mem_words; i++)
				shadow_mem[i] = prog_image[i];
			for (int i = 0; i < 32; i++)
				shadow_regs[i] = '0;
			model_pc = reset_pc;
			model_halted = 1'b0;
			model_illegal = 1'b0;
			release_seen = 1'b0;
			finished_seen = 1'b0;
			prev_wb = 1'b0;
			error_count = 0;
			retire_count = 0;
		end else begin
			if (!release_seen) begin
				release_seen = 1'b1;
				if (wb_valid !== 1'b0 || finished !== 1'b0)
					protocol_error("wb_valid or finished not low after reset");
			end
			if (wb_valid === 1'b1) begin
				if (prev_wb)
					protocol_error("wb_valid high in two consecutive cycles");
				if (model_halted) begin
					protocol_error("retirement after the halting instruction");
				end else begin
					exec_model(want_pc, want_rd, want_data, want_next);
					if (model_illegal)
						protocol_error("model reached an unsupported instruction");
					if (retire_count == 0 && pc !== reset_pc)
						value_mismatch("first pc", reset_pc, pc);
					if (pc === poison_pc)
						protocol_error("poison word retired");
					if (pc !== want_pc)
						value_mismatch("pc", want_pc, pc);
					if (wb_rd !== want_rd)
						value_mismatch("wb_rd", 32'(want_rd), 32'(wb_rd));
					if (wb_data !== want_data)
						value_mismatch("wb_data", want_data, wb_data);
					model_pc = want_next;
				end
				retire_count++;
			end
			if (finished === 1'b1) begin
				if (!model_halted)
					protocol_error("finished raised before the halting instruction retired");
				if (!finished_seen && halt_ret !== shadow_regs[10])
					value_mismatch("halt_ret", shadow_regs[10], halt_ret);
				finished_seen = 1'b1;
			end else if (finished_seen) begin
				protocol_error("finished dropped after the halt");
			end
			prev_wb = (wb_valid === 1'b1);
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_top.sv */
`default_nettype none

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;
	import rv_pkg::*;

	localparam int finish_timeout = 20000;
	localparam int alu_count = 24;

	logic clk;
	logic rst_n;
	logic prog_we;
	logic [mem_aw-1:0] prog_addr;
	logic [31:0] prog_wdata;
	logic [31:0] pc;
	logic wb_valid;
	logic [4:0] wb_rd;
	logic [31:0] wb_data;
	logic finished;
	logic [31:0] halt_ret;

	logic [31:0] prog_q [$];
	logic [15:0] lfsr_state;
	int expected_retires;
	int poison_idx;
	int check_errors;
	int retire_count;
	int top_errors;
	int total_errors;
	int cycles;

	rv_soc_top rv_soc_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_wdata(prog_wdata),
		.pc(pc),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.finished(finished),
		.halt_ret(halt_ret)
	);

	tb_checker tb_checker_inst (
		.clk(clk),
		.rst_n(rst_n),
		.pc(pc),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.finished(finished),
		.halt_ret(halt_ret),
		.error_count(check_errors),
		.retire_count(retire_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////
	// program generation
	////////////////////////////////////////

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	function automatic logic [4:0] pick_reg();
		return 5'(32'd1 + rand_bits(4) % 32'd15); // x1 to x15
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic void emit(input logic [31:0] word, input bit counted);
		prog_q.push_back(word);
		if (counted)
			expected_retires++;
	endfunction

	function automatic void build_program();
		logic [2:0] kind;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		lfsr_state = 16'd36049;
		expected_retires = 0;
		for (int r = 1; r < 16; r++)
			emit(i_type(12'(rand_bits(12)), 5'd0, 3'b000, 5'(r), opc_op_imm), 1'b1);
		emit(u_type(20'h80001, 5'd16), 1'b1);
		emit(i_type(12'h800, 5'd16, 3'b000, 5'd16, opc_op_imm), 1'b1); // x16 at word 512
		for (int n = 0; n < alu_count; n++) begin
			kind = 3'(rand_bits(3));
			rd = pick_reg();
			rs1 = pick_reg();
			rs2 = pick_reg();
			case (kind)
				3'd0: emit(r_type(7'h00, rs2, rs1, 3'b000, rd), 1'b1);
				3'd1: emit(r_type(7'h20, rs2, rs1, 3'b000, rd), 1'b1);
				3'd2: emit(r_type(7'h00, rs2, rs1, 3'b111, rd), 1'b1);
				3'd3: emit(r_type(7'h00, rs2, rs1, 3'b110, rd), 1'b1);
				3'd4: emit(r_type(7'h00, rs2, rs1, 3'b100, rd), 1'b1);
				3'd5: emit(r_type(7'h00, rs2, rs1, 3'b010, rd), 1'b1);
				3'd6: emit(i_type(12'(rand_bits(12)), rs1, 3'b000, rd, opc_op_imm), 1'b1);
				default: emit(u_type(20'(rand_bits(20)), rd), 1'b1);
			endcase
		end
		emit(i_type(12'd123, 5'd5, 3'b000, 5'd0, opc_op_imm), 1'b1); // dropped write
		emit(r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd0), 1'b1);
		emit(r_type(7'h00, 5'd5, 5'd0, 3'b000, 5'd6), 1'b1); // x6 = x0 + x5
		// one word per lane, sb lands on lane w of word w
		for (int w = 0; w < 4; w++) begin
			emit(s_type(12'(4 * w), pick_reg(), 5'd16, 3'b010), 1'b1);
			emit(s_type(12'(5 * w), pick_reg(), 5'd16, 3'b000), 1'b1);
			emit(i_type(12'(4 * w), 5'd16, 3'b010, 5'd17, opc_load), 1'b1);
			emit(i_type(12'(5 * w), 5'd16, 3'b000, 5'd18, opc_load), 1'b1);
			emit(i_type(12'(4 * w + (w + 1) % 4), 5'd16, 3'b100, 5'd19, opc_load), 1'b1);
		end
		emit(i_type(12'hffd, 5'd0, 3'b000, 5'd21, opc_op_imm), 1'b1);
		emit(s_type(12'd16, 5'd0, 5'd16, 3'b010), 1'b1);
		emit(s_type(12'd18, 5'd21, 5'd16, 3'b000), 1'b1); // negative byte in lane 2
		emit(i_type(12'd18, 5'd16, 3'b000, 5'd22, opc_load), 1'b1);
		emit(i_type(12'd18, 5'd16, 3'b100, 5'd23, opc_load), 1'b1);
		emit(i_type(12'd16, 5'd16, 3'b010, 5'd24, opc_load), 1'b1);
		emit(i_type(12'd5, 5'd0, 3'b000, 5'd25, opc_op_imm), 1'b1);
		emit(i_type(12'hfff, 5'd25, 3'b000, 5'd25, opc_op_imm), 1'b0);
		emit(b_type(13'h1ffc, 5'd0, 5'd25, 3'b001), 1'b0);
		expected_retires += 10; // five passes of addi and bne
		emit(b_type(13'd8, 5'd0, 5'd25, 3'b000), 1'b1);
		emit(i_type(12'd1, 5'd0, 3'b000, 5'd26, opc_op_imm), 1'b0);
		emit(j_type(21'd8, 5'd27), 1'b1);
		poison_idx = prog_q.size();
		emit(32'h0000_0000, 1'b0);
		emit(r_type(7'h00, 5'd27, 5'd10, 3'b100, 5'd10), 1'b1);
		emit(32'h0010_0073, 1'b1);
	endfunction

	////////////////////////////////////////
	// stimulus and report
	////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_wdata = '0;
		top_errors = 0;
		build_program();
		for (int i = 0; i < mem_words; i++)
			tb_checker_inst.prog_image[i] = (i < prog_q.size()) ? prog_q[i] : 32'h0;
		tb_checker_inst.poison_pc = reset_pc + 32'(poison_idx) * 32'd4;

		// reset covers the image load and then ten more cycles
		for (int i = 0; i < prog_q.size(); i++) begin
			@(posedge clk);
			#2;
			prog_we = 1'b1;
			prog_addr = mem_aw'(i);
			prog_wdata = prog_q[i];
		end
		@(posedge clk);
		#2;
		prog_we = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;

		cycles = 0;
		while (finished !== 1'b1 && cycles < finish_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (finished !== 1'b1) begin
			$display("timeout waiting for finished after %0d cycles", cycles);
			top_errors++;
		end
		repeat (20) @(posedge clk); // finished must hold and no retirement may follow

		if (retire_count != expected_retires) begin
			$display("Fail at %0t ns: retire count expected %0d, got %0d", $time,
				expected_retires, retire_count);
			top_errors++;
		end
		total_errors = check_errors + top_errors;
		$display("errors: %0d, retired: %0d of %0d", total_errors, retire_count,
			expected_retires);
		if (total_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
